// File: source/rsPkg.sv
//##############################
// rob tags and broadcast tags share one width
// depth must stay a power of two to match rsIdxW
//##############################

package rsPkg;

    // station geometry
    localparam int rsDepth  = 16;
    localparam int rsIdxW   = 4;   // log2 of rsDepth
    localparam int rsCountW = 5;   // holds 0 to rsDepth inclusive

    // datapath widths
    localparam int dataW    = 32;  // operand values and pc
    localparam int immW     = 32;
    localparam int opIdW    = 6;

    // reorder buffer tag also carried on the result broadcast
    localparam int robTagW  = 4;

endpackage

// File: source/rsOperandBank.sv
//##############################
// one source operand for every slot that wakes on a matching broadcast
// read port follows issueIdx combinationally
//##############################

`timescale 1ns/1ps

module rsOperandBank import rsPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 flush,
    input  logic                 insertEn,
    input  logic [rsIdxW-1:0]    insIdx,
    input  logic                 srcReady,
    input  logic [dataW-1:0]     srcValue,
    input  logic [robTagW-1:0]   srcTag,
    input  logic                 cdbValid,
    input  logic [robTagW-1:0]   cdbTag,
    input  logic [dataW-1:0]     cdbValue,
    input  logic                 issueHit,
    input  logic [rsIdxW-1:0]    issueIdx,
    output logic [rsDepth-1:0]   slotReady,
    output logic [dataW-1:0]     operandOut
);

    logic [rsDepth-1:0] readyQ;                 // operand value is final
    logic [robTagW-1:0] tagQ   [rsDepth];       // producer tag while waiting
    logic [dataW-1:0]   valueQ [rsDepth];

    logic [rsDepth-1:0] wakeHit;                // waiting slot sees its producer
    logic               insBypass;              // incoming operand produced this cycle
    logic               insReady;
    logic [dataW-1:0]   insValue;

    // tag compare per slot
    always_comb begin
        for (int i = 0; i < rsDepth; i++) begin
            wakeHit[i] = cdbValid && !readyQ[i] && (tagQ[i] == cdbTag);
        end
    end

    // same cycle broadcast for the operand being inserted
    assign insBypass = cdbValid && !srcReady && (srcTag == cdbTag);
    assign insReady  = srcReady || insBypass;
    assign insValue  = insBypass ? cdbValue : srcValue;

    // ready flags
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readyQ <= '0;
        end else if (flush) begin
            readyQ <= '0;                       // station emptied
        end else begin
            readyQ <= readyQ | wakeHit;
            if (issueHit) begin
                readyQ[issueIdx] <= 1'b0;      // slot leaves with the issue
            end
            if (insertEn) begin
                readyQ[insIdx] <= insReady;    // refill of an issuing slot wins
            end
        end
    end

    // tag and value storage
    always_ff @(posedge clk) begin
        for (int i = 0; i < rsDepth; i++) begin
            if (wakeHit[i]) begin
                valueQ[i] <= cdbValue;
            end
        end
        if (insertEn) begin
            tagQ[insIdx]   <= srcTag;
            valueQ[insIdx] <= insValue;
        end
    end

    assign slotReady  = readyQ;
    assign operandOut = valueQ[issueIdx];     // consumed by the issue register

endmodule

// File: source/rsEntryPicker.sv
//##############################
// insert while full is a caller error and lands in slot 0
//##############################

`timescale 1ns/1ps

module rsEntryPicker import rsPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 flush,
    input  logic                 insValid,
    input  logic [rsDepth-1:0]   rs1Ready,
    input  logic [rsDepth-1:0]   rs2Ready,
    output logic                 issueHit,
    output logic [rsIdxW-1:0]    issueIdx,
    output logic [rsIdxW-1:0]    insIdx,
    output logic                 insertEn
);

    logic [rsDepth-1:0] occQ;          // slot holds a live entry
    logic [rsDepth-1:0] slotReady;     // live with both operands final
    logic [rsDepth-1:0] issueOneHot;
    logic [rsDepth-1:0] slotFree;      // empty now or emptied by this issue

    // lowest set bit or index 0 for an empty vector
    function automatic logic [rsIdxW-1:0] lowestIdx(input logic [rsDepth-1:0] vec);
        logic [rsIdxW-1:0] idx;
        idx = '0;
        for (int i = rsDepth - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = rsIdxW'(i);
            end
        end
        return idx;
    endfunction

    assign slotReady = occQ & rs1Ready & rs2Ready;
    assign issueHit  = |slotReady;
    assign issueIdx  = lowestIdx(slotReady);

    always_comb begin
        issueOneHot           = '0;
        issueOneHot[issueIdx] = issueHit;
    end

    // issuing slot may be refilled on the same edge
    assign slotFree = ~occQ | issueOneHot;
    assign insIdx   = lowestIdx(slotFree);
    assign insertEn = insValid && !flush;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            occQ <= '0;
        end else if (flush) begin
            occQ <= '0;
        end else begin
            if (issueHit) begin
                occQ[issueIdx] <= 1'b0;
            end
            if (insertEn) begin
                occQ[insIdx] <= 1'b1;          // set after clear so refill wins
            end
        end
    end

endmodule

// File: source/rsOccupancyCounter.sv
//##############################
// full stays low in any cycle with an issue
//##############################

`timescale 1ns/1ps

module rsOccupancyCounter import rsPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  flush,
    input  logic  insertEn,
    input  logic  issueHit,
    output logic  full
);

    logic [rsCountW-1:0] countQ;       // live entries

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            countQ <= '0;
        end else if (flush) begin
            countQ <= '0;
        end else if (insertEn && !issueHit) begin
            countQ <= countQ + 1'b1;
        end else if (issueHit && !insertEn) begin
            countQ <= countQ - 1'b1;
        end
        // insert with issue leaves the count alone
    end

    // a slot freed by this cycle's issue can take the next insert
    assign full = (countQ == rsCountW'(rsDepth)) && !issueHit;

endmodule

// File: source/rsPayloadStore.sv
//##############################
// issue fields hold their last value while issueValid is low
//##############################

`timescale 1ns/1ps

module rsPayloadStore import rsPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 flush,
    input  logic                 insertEn,
    input  logic [rsIdxW-1:0]    insIdx,
    input  logic [dataW-1:0]     insPc,
    input  logic [opIdW-1:0]     insOpId,
    input  logic [immW-1:0]      insImm,
    input  logic [robTagW-1:0]   insRobTag,
    input  logic                 issueHit,
    input  logic [rsIdxW-1:0]    issueIdx,
    input  logic [dataW-1:0]     rs1Operand,
    input  logic [dataW-1:0]     rs2Operand,
    output logic                 issueValid,
    output logic [dataW-1:0]     issuePc,
    output logic [opIdW-1:0]     issueOpId,
    output logic [dataW-1:0]     issueRs1,
    output logic [dataW-1:0]     issueRs2,
    output logic [immW-1:0]      issueImm,
    output logic [robTagW-1:0]   issueRobTag
);

    // per slot instruction fields
    logic [dataW-1:0]   pcQ    [rsDepth];
    logic [opIdW-1:0]   opIdQ  [rsDepth];
    logic [immW-1:0]    immQ   [rsDepth];
    logic [robTagW-1:0] robTagQ[rsDepth];

    always_ff @(posedge clk) begin
        if (insertEn) begin
            pcQ[insIdx]     <= insPc;
            opIdQ[insIdx]   <= insOpId;
            immQ[insIdx]    <= insImm;
            robTagQ[insIdx] <= insRobTag;
        end
    end

    // output strobe
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= issueHit && !flush;  // flush drops the pick
        end
    end

    // output payload is read before a same edge refill overwrites the slot
    always_ff @(posedge clk) begin
        if (issueHit && !flush) begin
            issuePc     <= pcQ[issueIdx];
            issueOpId   <= opIdQ[issueIdx];
            issueImm    <= immQ[issueIdx];
            issueRobTag <= robTagQ[issueIdx];
            issueRs1    <= rs1Operand;         // banks already index issueIdx
            issueRs2    <= rs2Operand;
        end
    end

endmodule

// File: source/rsvStation.sv
//##############################
// insValid must stay low while full is high
// every issueValid pulse must be taken since issue never stalls
//##############################

`timescale 1ns/1ps

module rsvStation import rsPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    // instruction in
    input  logic                 insValid,
    input  logic [dataW-1:0]     insPc,
    input  logic [opIdW-1:0]     insOpId,
    input  logic [immW-1:0]      insImm,
    input  logic [robTagW-1:0]   insRobTag,
    input  logic                 rs1Ready,
    input  logic [dataW-1:0]     rs1Value,
    input  logic [robTagW-1:0]   rs1Tag,
    input  logic                 rs2Ready,
    input  logic [dataW-1:0]     rs2Value,
    input  logic [robTagW-1:0]   rs2Tag,
    // result broadcast
    input  logic                 cdbValid,
    input  logic [robTagW-1:0]   cdbTag,
    input  logic [dataW-1:0]     cdbValue,
    input  logic                 flush,     // level rollback
    output logic                 full,
    // registered issue outputs
    output logic                 issueValid,
    output logic [dataW-1:0]     issuePc,
    output logic [opIdW-1:0]     issueOpId,
    output logic [dataW-1:0]     issueRs1,
    output logic [dataW-1:0]     issueRs2,
    output logic [immW-1:0]      issueImm,
    output logic [robTagW-1:0]   issueRobTag
);

    logic [rsDepth-1:0] rs1SlotReady;
    logic [rsDepth-1:0] rs2SlotReady;
    logic               issueHit;
    logic [rsIdxW-1:0]  issueIdx;
    logic [rsIdxW-1:0]  insIdx;
    logic               insertEn;
    logic [dataW-1:0]   rs1Operand;
    logic [dataW-1:0]   rs2Operand;

    rsEntryPicker picker_i (
        .clk(clk), .arstN(arstN), .flush(flush), .insValid(insValid),
        .rs1Ready(rs1SlotReady), .rs2Ready(rs2SlotReady),
        .issueHit(issueHit), .issueIdx(issueIdx), .insIdx(insIdx), .insertEn(insertEn)
    );

    rsOccupancyCounter counter_i (
        .clk(clk), .arstN(arstN), .flush(flush),
        .insertEn(insertEn), .issueHit(issueHit), .full(full)
    );

    rsOperandBank rs1Bank (
        .clk(clk), .arstN(arstN), .flush(flush), .insertEn(insertEn), .insIdx(insIdx),
        .srcReady(rs1Ready), .srcValue(rs1Value), .srcTag(rs1Tag),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbValue(cdbValue),
        .issueHit(issueHit), .issueIdx(issueIdx),
        .slotReady(rs1SlotReady), .operandOut(rs1Operand)
    );

    rsOperandBank rs2Bank (
        .clk(clk), .arstN(arstN), .flush(flush), .insertEn(insertEn), .insIdx(insIdx),
        .srcReady(rs2Ready), .srcValue(rs2Value), .srcTag(rs2Tag),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbValue(cdbValue),
        .issueHit(issueHit), .issueIdx(issueIdx),
        .slotReady(rs2SlotReady), .operandOut(rs2Operand)
    );

    rsPayloadStore store_i (
        .clk(clk), .arstN(arstN), .flush(flush), .insertEn(insertEn), .insIdx(insIdx),
        .insPc(insPc), .insOpId(insOpId), .insImm(insImm), .insRobTag(insRobTag),
        .issueHit(issueHit), .issueIdx(issueIdx),
        .rs1Operand(rs1Operand), .rs2Operand(rs2Operand),
        .issueValid(issueValid), .issuePc(issuePc), .issueOpId(issueOpId),
        .issueRs1(issueRs1), .issueRs2(issueRs2), .issueImm(issueImm),
        .issueRobTag(issueRobTag)
    );

endmodule

// File: test/rsvStation_chk.sv
//##############################
// bound to every rsvStation instance
// assertions are disabled while arstN is low
//##############################

`timescale 1ns/1ps

module rsvStationChk import rsPkg::*; (
    input logic                 clk,
    input logic                 arstN,
    input logic                 insValid,
    input logic                 full,
    input logic                 flush,
    input logic                 issueValid,
    input logic [dataW-1:0]     issuePc,
    input logic [opIdW-1:0]     issueOpId,
    input logic [dataW-1:0]     issueRs1,
    input logic [dataW-1:0]     issueRs2,
    input logic [immW-1:0]      issueImm,
    input logic [robTagW-1:0]   issueRobTag
);

    // caller must hold off while full
    noInsertWhenFull: assert property (@(posedge clk) disable iff (!arstN)
        !(insValid && full))
        else $error("insert requested while the station is full");

    flushKillsIssue: assert property (@(posedge clk) disable iff (!arstN)
        flush |=> !issueValid)
        else $error("issueValid high in the cycle after a flush");

    issueKnown: assert property (@(posedge clk) disable iff (!arstN)
        issueValid |-> !$isunknown({issuePc, issueOpId, issueRs1, issueRs2,
                                    issueImm, issueRobTag}))
        else $error("unknown bits on the issue outputs");

endmodule

bind rsvStation rsvStationChk chk_i (
    .clk(clk), .arstN(arstN), .insValid(insValid), .full(full), .flush(flush),
    .issueValid(issueValid), .issuePc(issuePc), .issueOpId(issueOpId),
    .issueRs1(issueRs1), .issueRs2(issueRs2), .issueImm(issueImm),
    .issueRobTag(issueRobTag)
);

// File: test/rsvStationTb.sv
//##############################
// random traffic checked against a slot accurate model
// ends with a sweep of every broadcast tag to drain the station
//##############################

`timescale 1ns/1ps

module rsvStationTb import rsPkg::*; ();

    localparam int numCycles  = 3000;
    localparam int drainLimit = 100;    // cycles allowed to empty the station at the end

    logic                 clk;
    logic                 arstN;
    logic                 insValid;
    logic [dataW-1:0]     insPc;
    logic [opIdW-1:0]     insOpId;
    logic [immW-1:0]      insImm;
    logic [robTagW-1:0]   insRobTag;
    logic                 rs1Ready;
    logic [dataW-1:0]     rs1Value;
    logic [robTagW-1:0]   rs1Tag;
    logic                 rs2Ready;
    logic [dataW-1:0]     rs2Value;
    logic [robTagW-1:0]   rs2Tag;
    logic                 cdbValid;
    logic [robTagW-1:0]   cdbTag;
    logic [dataW-1:0]     cdbValue;
    logic                 flush;
    logic                 full;
    logic                 issueValid;
    logic [dataW-1:0]     issuePc;
    logic [opIdW-1:0]     issueOpId;
    logic [dataW-1:0]     issueRs1;
    logic [dataW-1:0]     issueRs2;
    logic [immW-1:0]      issueImm;
    logic [robTagW-1:0]   issueRobTag;

    integer seed = 32'he4f5;
    logic [robTagW-1:0] nextRob;        // tag for the next insert

    // model of every slot
    bit                 mOcc  [rsDepth];
    bit                 mRdy1 [rsDepth];
    bit                 mRdy2 [rsDepth];
    logic [robTagW-1:0] mTag1 [rsDepth];
    logic [robTagW-1:0] mTag2 [rsDepth];
    logic [dataW-1:0]   mVal1 [rsDepth];
    logic [dataW-1:0]   mVal2 [rsDepth];
    logic [dataW-1:0]   mPc   [rsDepth];
    logic [opIdW-1:0]   mOpId [rsDepth];
    logic [immW-1:0]    mImm  [rsDepth];
    logic [robTagW-1:0] mRob  [rsDepth];

    // what the issue register should hold after the next edge
    bit                 expValid;
    logic [dataW-1:0]   expPc;
    logic [dataW-1:0]   expRs1;
    logic [dataW-1:0]   expRs2;
    logic [opIdW-1:0]   expOpId;
    logic [immW-1:0]    expImm;
    logic [robTagW-1:0] expRob;

    rsvStation dut_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic bit rollPercent(input int pct);
        int roll;
        roll = ($random(seed) & 32'h7fff_ffff) % 100;
        return roll < pct;
    endfunction

    // one of the last four rob tags handed out
    function automatic logic [robTagW-1:0] recentTag();
        logic [robTagW-1:0] back;
        back = robTagW'($random(seed) & 3) + robTagW'(1);
        return nextRob - back;
    endfunction

    function automatic int lowestReady();
        for (int i = 0; i < rsDepth; i++) begin
            if (mOcc[i] && mRdy1[i] && mRdy2[i]) return i;
        end
        return -1;
    endfunction

    function automatic int lowestFree(input int issueSlot);
        for (int i = 0; i < rsDepth; i++) begin
            if (!mOcc[i] || i == issueSlot) return i;   // issuing slot reusable
        end
        return -1;
    endfunction

    function automatic int modelCount();
        int n;
        n = 0;
        for (int i = 0; i < rsDepth; i++) n += mOcc[i];
        return n;
    endfunction

    function automatic bit modelFull();
        return modelCount() == rsDepth && lowestReady() < 0;
    endfunction

    task automatic checkOutputs();
        assert (issueValid === expValid) else
            stopRun($sformatf("ERROR %0d ns: issueValid %b, expected %b",
                $time, issueValid, expValid));
        if (expValid) begin
            assert ({issuePc, issueOpId, issueImm, issueRobTag} ===
                    {expPc, expOpId, expImm, expRob}) else
                stopRun($sformatf("ERROR %0d ns: pc/op/imm/rob %h %h %h %h, exp %h %h %h %h",
                    $time, issuePc, issueOpId, issueImm, issueRobTag,
                    expPc, expOpId, expImm, expRob));
            assert (issueRs1 === expRs1) else
                stopRun($sformatf("ERROR %0d ns: issueRs1 %h, expected %h",
                    $time, issueRs1, expRs1));
            assert (issueRs2 === expRs2) else
                stopRun($sformatf("ERROR %0d ns: issueRs2 %h, expected %h",
                    $time, issueRs2, expRs2));
        end
        assert (full === modelFull()) else
            stopRun($sformatf("ERROR %0d ns: full %b, expected %b",
                $time, full, modelFull()));
    endtask

    task automatic driveRandom();
        flush     = (($random(seed) & 32'hff) == 0);      // about one in 256
        insValid  = !modelFull() && rollPercent(65);
        insPc     = $random(seed);
        insOpId   = opIdW'($random(seed));
        insImm    = $random(seed);
        insRobTag = nextRob;
        rs1Ready  = rollPercent(50);
        rs1Value  = $random(seed);
        rs1Tag    = recentTag();
        rs2Ready  = rollPercent(50);
        rs2Value  = $random(seed);
        rs2Tag    = recentTag();
        cdbValid  = rollPercent(60);
        cdbTag    = rollPercent(85) ? recentTag() : robTagW'($random(seed));
        cdbValue  = $random(seed);
        if (insValid) nextRob = nextRob + robTagW'(1);
    endtask

    // sweep every tag so waiting operands all wake
    task automatic driveDrain(input int step);
        insValid = 1'b0;
        flush    = 1'b0;
        cdbValid = 1'b1;
        cdbTag   = robTagW'(step);
        cdbValue = $random(seed);
    endtask

    // model of one clock edge with the inputs now on the pins
    task automatic advanceModel();
        int iss;
        int ins;
        iss = lowestReady();
        ins = lowestFree(iss);
        if (flush) begin
            expValid = 1'b0;
            for (int i = 0; i < rsDepth; i++) mOcc[i] = 1'b0;
        end else begin
            expValid = (iss >= 0);
            if (iss >= 0) begin
                expPc   = mPc[iss];
                expOpId = mOpId[iss];
                expImm  = mImm[iss];
                expRob  = mRob[iss];
                expRs1  = mVal1[iss];
                expRs2  = mVal2[iss];
                mOcc[iss] = 1'b0;
            end
            for (int i = 0; i < rsDepth; i++) begin
                if (cdbValid && mOcc[i] && !mRdy1[i] && mTag1[i] == cdbTag) begin
                    mRdy1[i] = 1'b1;
                    mVal1[i] = cdbValue;
                end
                if (cdbValid && mOcc[i] && !mRdy2[i] && mTag2[i] == cdbTag) begin
                    mRdy2[i] = 1'b1;
                    mVal2[i] = cdbValue;
                end
            end
            if (insValid) begin
                mOcc[ins]  = 1'b1;
                mPc[ins]   = insPc;
                mOpId[ins] = insOpId;
                mImm[ins]  = insImm;
                mRob[ins]  = insRobTag;
                mTag1[ins] = rs1Tag;
                mTag2[ins] = rs2Tag;
                mRdy1[ins] = rs1Ready || (cdbValid && rs1Tag == cdbTag);  // same cycle bypass
                mVal1[ins] = rs1Ready ? rs1Value : cdbValue;
                mRdy2[ins] = rs2Ready || (cdbValid && rs2Tag == cdbTag);
                mVal2[ins] = rs2Ready ? rs2Value : cdbValue;
            end
        end
    endtask

    initial begin
        int drainCycles;
        arstN    = 1'b0;
        nextRob  = '0;
        expValid = 1'b0;
        driveDrain(0);
        cdbValid = 1'b0;
        {insPc, insOpId, insImm, insRobTag} = '0;
        {rs1Ready, rs1Value, rs1Tag, rs2Ready, rs2Value, rs2Tag} = '0;
        for (int i = 0; i < rsDepth; i++) mOcc[i] = 1'b0;
        repeat (10) @(posedge clk);
        #1 arstN = 1'b1;

        for (int c = 0; c < numCycles; c++) begin
            checkOutputs();
            driveRandom();
            advanceModel();
            @(posedge clk);
            #1;
        end

        drainCycles = 0;
        while (modelCount() != 0 || expValid) begin
            if (drainCycles >= drainLimit) begin
                stopRun("Timeout: the station did not empty while every tag was broadcast");
            end else begin
                checkOutputs();
                driveDrain(drainCycles);
                advanceModel();
                @(posedge clk);
                #1;
                drainCycles++;
            end
        end
        checkOutputs();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: sources.f
source/rsPkg.sv
source/rsOperandBank.sv
source/rsEntryPicker.sv
source/rsOccupancyCounter.sv
source/rsPayloadStore.sv
source/rsvStation.sv
test/rsvStation_chk.sv
test/rsvStationTb.sv

// File: run.sh
#!/bin/sh
# builds and runs the reservation station testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module rsvStationTb \
    -f sources.f \
    -o rsvStationSim

status=0
./obj_dir/rsvStationSim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
exit 0
